/* build.f */
logic/cache_pkg.sv
logic/line_array.sv
logic/cache_datapath.sv
logic/cache_control.sv
logic/pmem_arbiter.sv
logic/cache_subsystem.sv
verification/cache_checker.sv
verification/cache_tb.sv

/* logic/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_pkg::cache_req_t        cpu_req,
    output cache_pkg::cache_resp_t       cpu_resp,
    input  logic                         hit,
    input  logic                         victim_dirty,
    input  logic [cache_pkg::S_WORD-1:0] rdata,
    input  logic [31:0]                  pmem_address,
    input  logic [cache_pkg::S_WORD-1:0] pmem_wdata,
    output cache_pkg::cache_req_t        held_req,
    output cache_pkg::dp_ctrl_t          ctrl,
    output cache_pkg::pmem_req_t         mem_req,
    input  cache_pkg::pmem_resp_t        mem_resp
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        RESPOND
    } state_t;

    state_t            state;
    state_t            state_next;
    logic              issue;
    logic [S_WORD-1:0] rdata_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cpu_req.read || cpu_req.write) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_next = RESPOND;
                end else if (victim_dirty) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = FILL;
                end
            end
            WRITEBACK: if (mem_resp.resp) state_next = FILL;
            FILL:      if (mem_resp.resp) state_next = LOOKUP;
            RESPOND:   state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    // Issue is high only in the first cycle of a memory state.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            issue <= 1'b0;
        end else begin
            state <= state_next;
            issue <= (state_next != state) &&
                     ((state_next == WRITEBACK) || (state_next == FILL));
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && (cpu_req.read || cpu_req.write)) begin
            held_req <= cpu_req;
        end
        if (state == LOOKUP) begin
            rdata_q <= rdata;
        end
    end

    always_comb begin
        ctrl = '0;
        case (state)
            LOOKUP: begin
                ctrl.ld_plru = hit;
                if (hit && held_req.write) begin
                    ctrl.ld_data   = 1'b1;
                    ctrl.ld_dirty  = 1'b1;
                    ctrl.dirty_val = 1'b1;
                end
            end
            WRITEBACK: ctrl.wb_addr_sel = 1'b1;
            FILL: begin
                // The line lands clean in the victim way.
                ctrl.fill_sel = 1'b1;
                ctrl.ld_tag   = mem_resp.resp;
                ctrl.ld_valid = mem_resp.resp;
                ctrl.ld_data  = mem_resp.resp;
                ctrl.ld_dirty = mem_resp.resp;
            end
            default: ;
        endcase
    end

    always_comb begin
        mem_req.address = pmem_address;
        mem_req.read    = issue && (state == FILL);
        mem_req.write   = issue && (state == WRITEBACK);
        mem_req.wdata   = pmem_wdata;
    end

    assign cpu_resp.resp  = (state == RESPOND);
    assign cpu_resp.rdata = rdata_q;

endmodule : cache_control

/* logic/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_pkg::cache_req_t        req,
    input  cache_pkg::dp_ctrl_t          ctrl,
    input  logic [cache_pkg::S_WORD-1:0] fill_data,
    output logic [cache_pkg::S_WORD-1:0] rdata,
    output logic [31:0]                  pmem_address,
    output logic [cache_pkg::S_WORD-1:0] pmem_wdata,
    output logic                         hit,
    output logic                         victim_dirty
);
    import cache_pkg::*;

    logic [S_TAG-1:0]    addr_tag;
    logic [S_INDEX-1:0]  addr_index;

    logic [S_TAG-1:0]    tag_q   [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
    logic [2:0]          plru_q  [NUM_SETS];
    logic [S_WORD-1:0]   data_q  [NUM_WAYS];

    logic [S_WAYIDX-1:0] hit_way;
    logic [S_WAYIDX-1:0] victim_way;
    logic [NUM_WAYS-1:0] hit_mask;
    logic [NUM_WAYS-1:0] victim_mask;
    logic [NUM_WAYS-1:0] data_we;
    logic [NUM_WAYS-1:0] dirty_we;
    logic [2:0]          plru_set;
    logic [S_MASK-1:0]   line_mask;
    logic [S_WORD-1:0]   line_din;

    // The offset bits are dropped since a line is one bus word.
    assign addr_tag   = req.address[31 -: S_TAG];
    assign addr_index = req.address[S_OFFSET +: S_INDEX];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[w][addr_index] && (tag_q[w][addr_index] == addr_tag)) begin
                hit     = 1'b1;
                hit_way = w[S_WAYIDX-1:0];
            end
        end
    end

    // Bit 0 of the PLRU tree picks the half, bits 1 and 2 pick the way inside it.
    assign plru_set = plru_q[addr_index];

    always_comb begin
        if (!plru_set[0]) begin
            victim_way = {1'b0, plru_set[1]};
        end else begin
            victim_way = {1'b1, plru_set[2]};
        end
    end

    assign hit_mask    = {{(NUM_WAYS-1){1'b0}}, 1'b1} << hit_way;
    assign victim_mask = {{(NUM_WAYS-1){1'b0}}, 1'b1} << victim_way;

    // A fill targets the victim way with a whole line; a client write targets the hit way.
    assign data_we   = {NUM_WAYS{ctrl.ld_data}} & (ctrl.fill_sel ? victim_mask : hit_mask);
    assign dirty_we  = {NUM_WAYS{ctrl.ld_dirty}} & (ctrl.fill_sel ? victim_mask : hit_mask);
    assign line_mask = ctrl.fill_sel ? {S_MASK{1'b1}} : req.byte_enable;
    assign line_din  = ctrl.fill_sel ? fill_data : req.wdata;

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        line_array u_lines (
            .clk   (clk),
            .we    (data_we[i]),
            .wmask (line_mask),
            .index (addr_index),
            .din   (line_din),
            .dout  (data_q[i])
        );
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (rst) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end else begin
                if (ctrl.ld_valid && victim_mask[w]) begin
                    valid_q[w][addr_index] <= 1'b1;
                end
                if (dirty_we[w]) begin
                    dirty_q[w][addr_index] <= ctrl.dirty_val;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ctrl.ld_tag && victim_mask[w]) begin
                tag_q[w][addr_index] <= addr_tag;
            end
        end
    end

    // Point the tree away from the way just used.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (ctrl.ld_plru) begin
            plru_q[addr_index][0] <= ~hit_way[1];
            if (hit_way[1]) begin
                plru_q[addr_index][2] <= ~hit_way[0];
            end else begin
                plru_q[addr_index][1] <= ~hit_way[0];
            end
        end
    end

    assign rdata        = data_q[hit_way];
    assign pmem_wdata   = data_q[victim_way];
    assign victim_dirty = valid_q[victim_way][addr_index] & dirty_q[victim_way][addr_index];

    // Writeback goes to the victim's own line, a fill to the requested one.
    assign pmem_address = {ctrl.wb_addr_sel ? tag_q[victim_way][addr_index] : addr_tag,
                           addr_index, {S_OFFSET{1'b0}}};

endmodule : cache_datapath

/* logic/cache_pkg.sv */
package cache_pkg;

    // Cache geometry. One line is exactly one memory bus word.
    localparam int S_WORD   = 256;
    localparam int S_MASK   = S_WORD / 8;
    localparam int S_OFFSET = 5;
    localparam int S_INDEX  = 4;
    localparam int S_WAYIDX = 2;
    localparam int NUM_SETS = 2 ** S_INDEX;
    localparam int NUM_WAYS = 2 ** S_WAYIDX;
    localparam int S_TAG    = 32 - S_OFFSET - S_INDEX;

    // Client side.
    typedef struct packed {
        logic [31:0]       address;
        logic              read;
        logic              write;
        logic [S_MASK-1:0] byte_enable;
        logic [S_WORD-1:0] wdata;
    } cache_req_t;

    typedef struct packed {
        logic              resp;
        logic [S_WORD-1:0] rdata;
    } cache_resp_t;

    // Memory bus side. Addresses are line aligned.
    typedef struct packed {
        logic [31:0]       address;
        logic              read;
        logic              write;
        logic [S_WORD-1:0] wdata;
    } pmem_req_t;

    typedef struct packed {
        logic              resp;
        logic [S_WORD-1:0] rdata;
    } pmem_resp_t;

    // Control word from the FSM to the datapath.
    typedef struct packed {
        logic ld_tag;
        logic ld_valid;
        logic ld_data;
        logic ld_dirty;
        logic ld_plru;
        logic dirty_val;
        logic fill_sel;
        logic wb_addr_sel;
    } dp_ctrl_t;

endpackage : cache_pkg

/* logic/cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::cache_req_t  port_a_req,
    input  cache_pkg::cache_req_t  port_b_req,
    output cache_pkg::cache_resp_t port_a_resp,
    output cache_pkg::cache_resp_t port_b_resp,
    output cache_pkg::pmem_req_t   pmem_req,
    input  cache_pkg::pmem_resp_t  pmem_resp
);
    import cache_pkg::*;

    // Index 0 is port a, index 1 is port b.
    cache_req_t  port_req  [2];
    cache_resp_t port_resp [2];
    pmem_req_t   mem_req   [2];
    pmem_resp_t  mem_resp  [2];

    assign port_req[0] = port_a_req;
    assign port_req[1] = port_b_req;
    assign port_a_resp = port_resp[0];
    assign port_b_resp = port_resp[1];

    for (genvar p = 0; p < 2; p++) begin : g_port
        cache_req_t        held_req;
        dp_ctrl_t          ctrl;
        logic              hit;
        logic              victim_dirty;
        logic [S_WORD-1:0] rdata;
        logic [S_WORD-1:0] pmem_wdata;
        logic [31:0]       pmem_address;

        cache_control u_control (
            .clk          (clk),
            .rst          (rst),
            .cpu_req      (port_req[p]),
            .cpu_resp     (port_resp[p]),
            .hit          (hit),
            .victim_dirty (victim_dirty),
            .rdata        (rdata),
            .pmem_address (pmem_address),
            .pmem_wdata   (pmem_wdata),
            .held_req     (held_req),
            .ctrl         (ctrl),
            .mem_req      (mem_req[p]),
            .mem_resp     (mem_resp[p])
        );

        // Fill data comes straight off the routed memory response.
        cache_datapath u_datapath (
            .clk          (clk),
            .rst          (rst),
            .req          (held_req),
            .ctrl         (ctrl),
            .fill_data    (mem_resp[p].rdata),
            .rdata        (rdata),
            .pmem_address (pmem_address),
            .pmem_wdata   (pmem_wdata),
            .hit          (hit),
            .victim_dirty (victim_dirty)
        );
    end

    pmem_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .req_a    (mem_req[0]),
        .req_b    (mem_req[1]),
        .resp_a   (mem_resp[0]),
        .resp_b   (mem_resp[1]),
        .bus_req  (pmem_req),
        .bus_resp (pmem_resp)
    );

endmodule : cache_subsystem

/* logic/line_array.sv */
`timescale 1ns/1ps

module line_array (
    input  logic                          clk,
    input  logic                          we,
    input  logic [cache_pkg::S_MASK-1:0]  wmask,
    input  logic [cache_pkg::S_INDEX-1:0] index,
    input  logic [cache_pkg::S_WORD-1:0]  din,
    output logic [cache_pkg::S_WORD-1:0]  dout
);
    import cache_pkg::*;

    logic [S_WORD-1:0] lines [NUM_SETS];

    // Only the enabled bytes of the addressed line change.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < S_MASK; b++) begin
                if (wmask[b]) begin
                    lines[index][b*8 +: 8] <= din[b*8 +: 8];
                end
            end
        end
    end

    // Asynchronous read port.
    assign dout = lines[index];

endmodule : line_array

/* logic/pmem_arbiter.sv */
`timescale 1ns/1ps

module pmem_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::pmem_req_t  req_a,
    input  cache_pkg::pmem_req_t  req_b,
    output cache_pkg::pmem_resp_t resp_a,
    output cache_pkg::pmem_resp_t resp_b,
    output cache_pkg::pmem_req_t  bus_req,
    input  cache_pkg::pmem_resp_t bus_resp
);
    import cache_pkg::*;

    pmem_req_t slot_a;
    pmem_req_t slot_b;
    pmem_req_t cand_a;
    pmem_req_t cand_b;
    logic      slot_a_valid;
    logic      slot_b_valid;
    logic      busy;
    logic      owner;
    logic      last_served;
    logic      strobe_a;
    logic      strobe_b;
    logic      want_a;
    logic      want_b;
    logic      bus_free;
    logic      grant;
    logic      pick;

    // A fresh strobe competes directly so an idle bus forwards it next cycle.
    assign strobe_a = req_a.read | req_a.write;
    assign strobe_b = req_b.read | req_b.write;
    assign want_a   = slot_a_valid | strobe_a;
    assign want_b   = slot_b_valid | strobe_b;
    assign cand_a   = slot_a_valid ? slot_a : req_a;
    assign cand_b   = slot_b_valid ? slot_b : req_b;

    assign bus_free = !busy || bus_resp.resp;
    assign grant    = bus_free && (want_a || want_b);
    // Alternate when both wait, else serve whoever is asking. 1 means port b.
    assign pick     = (want_a && want_b) ? !last_served : want_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_a_valid  <= 1'b0;
            slot_b_valid  <= 1'b0;
            busy          <= 1'b0;
            owner         <= 1'b0;
            last_served   <= 1'b0;
            bus_req.read  <= 1'b0;
            bus_req.write <= 1'b0;
        end else begin
            bus_req.read  <= 1'b0;
            bus_req.write <= 1'b0;
            if (bus_resp.resp) begin
                busy <= 1'b0;
            end
            if (grant) begin
                bus_req     <= pick ? cand_b : cand_a;
                busy        <= 1'b1;
                owner       <= pick;
                last_served <= pick;
            end
            slot_a_valid <= want_a && !(grant && !pick);
            slot_b_valid <= want_b && !(grant && pick);
        end
    end

    always_ff @(posedge clk) begin
        if (strobe_a) slot_a <= req_a;
        if (strobe_b) slot_b <= req_b;
    end

    always_comb begin
        resp_a.resp  = bus_resp.resp && busy && !owner;
        resp_a.rdata = bus_resp.rdata;
        resp_b.resp  = bus_resp.resp && busy && owner;
        resp_b.rdata = bus_resp.rdata;
    end

endmodule : pmem_arbiter

/* verification/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker (
    input logic                   clk,
    input logic                   rst,
    input cache_pkg::cache_req_t  port_a_req,
    input cache_pkg::cache_req_t  port_b_req,
    input cache_pkg::cache_resp_t port_a_resp,
    input cache_pkg::cache_resp_t port_b_resp,
    input cache_pkg::pmem_req_t   pmem_req,
    input cache_pkg::pmem_resp_t  pmem_resp
);
    import cache_pkg::*;

    int     error_count = 0;
    int     test_count = 0;
    longint cycle = 0;

    // Client-visible image of every line in the address pool.
    logic [S_WORD-1:0] img [64];
    logic [63:0]       img_known = '0;

    // Per-port cache state as the clients should see it.
    logic [S_TAG-1:0]    tag_m   [2][NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_m [2][NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_m [2][NUM_WAYS];
    logic [2:0]          plru_m  [2][NUM_SETS];

    cache_req_t        pend      [2];
    logic              busy_p    [2];
    logic              was_hit   [2];
    longint            due       [2];
    int                err_start [2];
    int                num_done  [2];
    logic              want_wb   [2];
    logic              want_fill [2];
    logic [31:0]       wb_addr   [2];
    logic [S_WORD-1:0] wb_data   [2];

    // The single memory transaction on the bus.
    logic        fly_valid;
    logic        fly_read;
    int          fly_port;
    logic [31:0] fly_addr;

    function automatic int line_slot(input logic [31:0] addr);
        return {addr[31:28], addr[6:5]};
    endfunction

    // Bit 0 says which half was used less recently, bits 1 and 2 which way inside it.
    function automatic logic [1:0] plru_victim(input logic [2:0] t);
        return t[0] ? {1'b1, t[2]} : {1'b0, t[1]};
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] t, input logic [1:0] w);
        logic [2:0] n;
        n    = t;
        n[0] = ~w[1];
        if (w[1]) begin
            n[2] = ~w[0];
        end else begin
            n[1] = ~w[0];
        end
        return n;
    endfunction

    task automatic report_value(input string name, input logic [S_WORD-1:0] exp,
                                input logic [S_WORD-1:0] got);
        if (exp !== got) begin
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("t=%0t %s", $time, what);
        error_count++;
    endtask

    task automatic reset_model();
        for (int p = 0; p < 2; p++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_m[p][w] = '0;
                dirty_m[p][w] = '0;
            end
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_m[p][s] = '0;
            end
            busy_p[p]    = 1'b0;
            want_wb[p]   = 1'b0;
            want_fill[p] = 1'b0;
            due[p]       = -1;
            num_done[p]  = 0;
        end
        fly_valid = 1'b0;
    endtask

    // Predict hit or miss at the strobe and queue the memory traffic a miss needs.
    task automatic accept_request(input int p, input cache_req_t r);
        logic [S_TAG-1:0]   tag;
        logic [S_INDEX-1:0] idx;
        logic [1:0]         way;
        logic               hit;
        tag = r.address[31 -: S_TAG];
        idx = r.address[S_OFFSET +: S_INDEX];
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_m[p][w][idx] && (tag_m[p][w][idx] == tag)) begin
                hit = 1'b1;
                way = w[1:0];
            end
        end
        if (hit) begin
            due[p] = cycle + 2;
        end else begin
            way          = plru_victim(plru_m[p][idx]);
            want_wb[p]   = valid_m[p][way][idx] && dirty_m[p][way][idx];
            wb_addr[p]   = {tag_m[p][way][idx], idx, {S_OFFSET{1'b0}}};
            wb_data[p]   = img[line_slot(wb_addr[p])];
            want_fill[p] = 1'b1;
            due[p]       = -1;
            tag_m[p][way][idx]   = tag;
            valid_m[p][way][idx] = 1'b1;
            dirty_m[p][way][idx] = 1'b0;
        end
        if (r.write) begin
            dirty_m[p][way][idx] = 1'b1;
        end
        plru_m[p][idx] = plru_touch(plru_m[p][idx], way);
        pend[p]        = r;
        busy_p[p]      = 1'b1;
        was_hit[p]     = hit;
        err_start[p]   = error_count;
    endtask

    task automatic check_transfer();
        int p;
        p = pmem_req.address[31];
        if (fly_valid) begin
            report_problem("memory request issued while another transfer is in flight");
        end
        if (want_wb[p]) begin
            report_value("pmem_req.write", 1'b1, pmem_req.write);
            report_value("pmem_req.address", wb_addr[p], pmem_req.address);
            report_value("pmem_req.wdata", wb_data[p], pmem_req.wdata);
            want_wb[p] = 1'b0;
        end else if (want_fill[p]) begin
            report_value("pmem_req.read", 1'b1, pmem_req.read);
            report_value("pmem_req.address", {pend[p].address[31:S_OFFSET], 5'b0},
                         pmem_req.address);
            want_fill[p] = 1'b0;
        end else begin
            report_problem($sformatf("unexpected memory transfer for port %0d", p));
        end
        fly_valid = 1'b1;
        fly_read  = pmem_req.read;
        fly_port  = p;
        fly_addr  = pmem_req.address;
    endtask

    // A fill must return what the clients last saw of that line.
    task automatic finish_transfer();
        int k;
        if (fly_read) begin
            k = line_slot(fly_addr);
            if (img_known[k]) begin
                report_value("pmem_resp.rdata", img[k], pmem_resp.rdata);
            end else begin
                img[k]       = pmem_resp.rdata;
                img_known[k] = 1'b1;
            end
            due[fly_port] = cycle + 2;
        end
        fly_valid = 1'b0;
    endtask

    task automatic check_port(input int p, input cache_resp_t rsp, input string name);
        int k;
        if (rsp.resp) begin
            if (!busy_p[p]) begin
                report_value({name, ".resp"}, 1'b0, 1'b1);
            end else begin
                if (cycle != due[p]) begin
                    report_problem($sformatf("%s arrived at cycle %0d instead of %0d",
                                             name, cycle, due[p]));
                end
                k = line_slot(pend[p].address);
                if (pend[p].read) begin
                    report_value({name, ".rdata"}, img[k], rsp.rdata);
                end else begin
                    for (int b = 0; b < S_MASK; b++) begin
                        if (pend[p].byte_enable[b]) img[k][b*8 +: 8] = pend[p].wdata[b*8 +: 8];
                    end
                end
                test_count++;
                num_done[p]++;
                $display("%s test %0d: %s %h %s, %s", name, num_done[p],
                         pend[p].read ? "read" : "write", pend[p].address,
                         was_hit[p] ? "hit" : "miss",
                         (error_count == err_start[p]) ? "ok" : "mismatch");
                busy_p[p] = 1'b0;
            end
        end else if (busy_p[p] && (cycle == due[p])) begin
            report_value({name, ".resp"}, 1'b1, 1'b0);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            if (pmem_resp.resp) finish_transfer();
            if (pmem_req.read || pmem_req.write) check_transfer();
            check_port(0, port_a_resp, "port_a_resp");
            check_port(1, port_b_resp, "port_b_resp");
            if (port_a_req.read || port_a_req.write) accept_request(0, port_a_req);
            if (port_b_req.read || port_b_req.write) accept_request(1, port_b_req);
        end
        cycle++;
    end

endmodule : cache_checker

/* verification/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int NUM_REQS     = 120;
    localparam int RESP_TIMEOUT = 100;

    logic        clk;
    logic        rst;
    cache_req_t  port_a_req;
    cache_req_t  port_b_req;
    cache_resp_t port_a_resp;
    cache_resp_t port_b_resp;
    pmem_req_t   pmem_req;
    pmem_resp_t  pmem_resp;

    // Physical memory with one slot per line of the address pool.
    logic [S_WORD-1:0] mem [64];
    int                timeouts;

    cache_subsystem DUT (
        .clk         (clk),
        .rst         (rst),
        .port_a_req  (port_a_req),
        .port_b_req  (port_b_req),
        .port_a_resp (port_a_resp),
        .port_b_resp (port_b_resp),
        .pmem_req    (pmem_req),
        .pmem_resp   (pmem_resp)
    );

    cache_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .port_a_req  (port_a_req),
        .port_b_req  (port_b_req),
        .port_a_resp (port_a_resp),
        .port_b_resp (port_b_resp),
        .pmem_req    (pmem_req),
        .pmem_resp   (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [S_WORD-1:0] random_line();
        logic [S_WORD-1:0] v;
        for (int i = 0; i < S_WORD / 32; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic int line_slot(input logic [31:0] addr);
        return {addr[31:28], addr[6:5]};
    endfunction

    // Port b owns the upper half. Six tags share sets 0 to 3, so lines get evicted.
    function automatic logic [31:0] random_address(input int p);
        logic       port_bit;
        logic [2:0] tag_sel;
        logic [1:0] set_sel;
        logic [4:0] offset;
        port_bit = (p != 0);
        tag_sel  = $urandom % 6;
        set_sel  = $urandom;
        offset   = $urandom;
        return {port_bit, tag_sel, 19'h0, 2'b00, set_sel, offset};
    endfunction

    task automatic set_port_request(input int p, input cache_req_t r);
        if (p == 0) begin
            port_a_req <= r;
        end else begin
            port_b_req <= r;
        end
    endtask

    task automatic memory_responder();
        int delay;
        int slot;
        forever begin
            @(negedge clk);
            if (!rst && (pmem_req.read || pmem_req.write)) begin
                delay = 1 + $urandom % 8;
                slot  = line_slot(pmem_req.address);
                if (pmem_req.write) mem[slot] = pmem_req.wdata;
                repeat (delay) @(posedge clk);
                pmem_resp.rdata <= mem[slot];
                pmem_resp.resp  <= 1'b1;
                @(posedge clk);
                pmem_resp.resp  <= 1'b0;
            end
        end
    endtask

    task automatic client_port(input int p);
        cache_req_t r;
        int         waited;
        logic       seen;
        for (int n = 0; n < NUM_REQS; n++) begin
            repeat ($urandom % 3) @(posedge clk);
            r.address     = random_address(p);
            r.write       = $urandom % 2;
            r.read        = !r.write;
            r.byte_enable = $urandom;
            r.wdata       = random_line();
            @(posedge clk);
            set_port_request(p, r);
            @(posedge clk);
            r.read  = 1'b0;
            r.write = 1'b0;
            set_port_request(p, r);
            waited = 0;
            seen   = 1'b0;
            while (!seen && (waited < RESP_TIMEOUT)) begin
                @(negedge clk);
                waited++;
                seen = (p == 0) ? port_a_resp.resp : port_b_resp.resp;
            end
            if (!seen) begin
                $display("port %0d gave no response within %0d cycles", p, RESP_TIMEOUT);
                timeouts++;
                return;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h4ae32e7b));
        rst        = 1'b1;
        port_a_req = '0;
        port_b_req = '0;
        pmem_resp  = '0;
        timeouts   = 0;
        for (int s = 0; s < 64; s++) begin
            mem[s] = random_line();
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fork
            memory_responder();
        join_none
        fork
            client_port(0);
            client_port(1);
        join
        repeat (3) @(posedge clk);
        $display("tests %0d, errors %0d, timeouts %0d", u_checker.test_count,
                 u_checker.error_count, timeouts);
        if ((u_checker.error_count == 0) && (timeouts == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : cache_tb
